// File: bench/floor_request_ctrl_asserts.sv
// Concurrent checks on the dispatch handshake and door grants.
// Bound to dispatch_ctrl from the testbench top.

`timescale 1ns/100ps

module floor_request_ctrl_asserts (
    input logic                      clock,
    input logic                      reset_n,
    input elevator_pkg::car_status_t status,
    input elevator_pkg::dispatch_t   dispatch,
    input logic                      dispatch_valid,
    input logic                      dispatch_ready,
    input logic                      door_open_allowed,
    input logic                      door_close_allowed
);

    // Offer holds under back-pressure
    offer_stable: assert property (@(posedge clock) disable iff (!reset_n)
        dispatch_valid && !dispatch_ready |=> dispatch_valid && $stable(dispatch))
        else $error("dispatch offer changed before it was accepted");

    // No new offer while the car travels
    offer_when_stopped: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(dispatch_valid) |-> !$past(status.moving))
        else $error("dispatch_valid rose while the car was moving");

    doors_closed_moving: assert property (@(posedge clock) disable iff (!reset_n)
        status.moving |=> !door_open_allowed && !door_close_allowed)
        else $error("door grant high while the car was moving");

endmodule

// File: bench/floor_request_ctrl_tb.sv
// Testbench for the floor request controller.
// Reads scenarios from the golden file, models the car's travel and checks
// lights, dispatch order, back-pressure, power and emergency blocking and door grants.

`timescale 1ns/100ps

module floor_request_ctrl_tb;

    localparam int rec_words  = 14;
    localparam int max_recs   = 12;
    localparam int wait_limit = 60;

    logic                       clock = 1'b0;
    logic                       reset_n;
    elevator_pkg::button_bank_t buttons;
    elevator_pkg::car_status_t  status;
    logic                       door_open_button;
    logic                       door_close_button;
    logic                       dispatch_ready;
    elevator_pkg::dispatch_t    dispatch;
    logic                       dispatch_valid;
    elevator_pkg::button_bank_t lights;
    logic                       door_open_allowed;
    logic                       door_close_allowed;

    logic [11:0]                golden [0:rec_words*max_recs-1];
    elevator_pkg::button_bank_t exp_lights;
    int                         errors = 0;
    int                         seed = 73171;

    floor_request_ctrl uut (.*);

    bind dispatch_ctrl floor_request_ctrl_asserts u_asserts (
        .clock              (clock),
        .reset_n            (reset_n),
        .status             (status),
        .dispatch           (dispatch),
        .dispatch_valid     (dispatch_valid),
        .dispatch_ready     (dispatch_ready),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    always #20 clock = ~clock;

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    task automatic apply_reset(input elevator_pkg::floor_t start);
        reset_n        <= 1'b0;
        buttons        <= '0;
        dispatch_ready <= 1'b0;
        status <= '{floor: start, moving: 1'b0, power_on: 1'b1, emergency: 1'b0};
        exp_lights = '0;
        repeat (5) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
    endtask

    // One-cycle press with the lights checked one edge after it is sampled
    task automatic press_buttons(input elevator_pkg::button_bank_t press);
        elevator_pkg::floor_mask_t allowed;
        buttons <= press;
        @(posedge clock);
        buttons <= '0;
        allowed = ~(elevator_pkg::floor_mask_t'(1) << status.floor);
        if (!status.power_on || status.emergency) begin
            allowed = '0;
        end
        exp_lights.call  = exp_lights.call | (press.call & allowed);
        exp_lights.panel = exp_lights.panel | (press.panel & allowed);
        @(posedge clock);
        check_value("lights", int'(lights), int'(exp_lights));
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            check_value("dispatch_valid", int'(dispatch_valid), 0);
        end
    endtask

    // Wait for an offer, stall it, accept it, then move the car there
    task automatic serve_target(input elevator_pkg::floor_t target);
        elevator_pkg::dispatch_t offered;
        int                      stall;
        int                      n;
        n = 0;
        while (!dispatch_valid) begin
            @(posedge clock);
            n++;
            if (n > wait_limit) begin
                $display("No dispatch offer appeared for floor %0d", target);
                errors++;
                return;
            end
        end
        offered = dispatch;
        check_value("dispatch.floor", int'(dispatch.floor), int'(target));
        check_value("dispatch.up", int'(dispatch.up), int'(target > status.floor));
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) begin
            @(posedge clock);
            check_value("dispatch_valid", int'(dispatch_valid), 1);
            check_value("dispatch", int'(dispatch), int'(offered));
        end
        dispatch_ready <= 1'b1;
        @(posedge clock);
        check_value("dispatch_valid", int'(dispatch_valid), 1);
        check_value("dispatch", int'(dispatch), int'(offered));
        dispatch_ready <= 1'b0;
        @(posedge clock);
        status.moving <= 1'b1;
        repeat (3) @(posedge clock);
        status.floor  <= target;
        status.moving <= 1'b0;
        exp_lights.call[target]  = 1'b0;
        exp_lights.panel[target] = 1'b0;
        repeat (2) @(posedge clock);
        check_value("lights", int'(lights), int'(exp_lights));
    endtask

    task automatic check_doors(input logic open_press, input logic close_press,
                               input logic open_exp, input logic close_exp);
        door_open_button  <= open_press;
        door_close_button <= close_press;
        repeat (2) @(posedge clock);
        check_value("door_open_allowed", int'(door_open_allowed), int'(open_exp));
        check_value("door_close_allowed", int'(door_close_allowed), int'(close_exp));
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        reset_n           <= 1'b0;
        buttons           <= '0;
        status            <= '0;
        door_open_button  <= 1'b0;
        door_close_button <= 1'b0;
        dispatch_ready    <= 1'b0;
        $readmemh("bench/floor_request_golden.txt", golden);
        for (int r = 0; r < max_recs && golden[r*rec_words] != 12'h00f; r++) begin
            apply_reset(golden[r*rec_words][3:0]);
            press_buttons({golden[r*rec_words+1][10:0], golden[r*rec_words+2][10:0]});
            for (int k = 3; k < rec_words && golden[r*rec_words+k] != 12'h00f; k++) begin
                serve_target(golden[r*rec_words+k][3:0]);
            end
            check_quiet(8);
            check_value("lights", int'(lights), 0);
        end

        // Emergency and power off block latching and new offers
        apply_reset(4'd3);
        status.emergency <= 1'b1;
        press_buttons('{call: 11'h0f0, panel: 11'h00f});
        status.emergency <= 1'b0;
        status.power_on  <= 1'b0;
        press_buttons('{call: 11'h0f0, panel: 11'h00f});
        status.power_on <= 1'b1;
        buttons <= '{call: 11'h100, panel: 11'h000};
        @(posedge clock);
        buttons <= '0;
        status.emergency <= 1'b1;
        exp_lights.call[8] = 1'b1;
        check_quiet(8);
        status.emergency <= 1'b0;
        status.power_on  <= 1'b0;
        check_quiet(8);
        status.power_on <= 1'b1;
        serve_target(4'd8);

        // Door grants while stopped, moving and unpowered
        check_doors(1'b1, 1'b0, 1'b1, 1'b0);
        check_doors(1'b0, 1'b1, 1'b0, 1'b1);
        status.moving <= 1'b1;
        check_doors(1'b1, 1'b1, 1'b0, 1'b0);
        status.moving   <= 1'b0;
        status.power_on <= 1'b0;
        check_doors(1'b1, 1'b1, 1'b0, 1'b0);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: bench/floor_request_golden.txt
// Columns: start floor, call mask, panel mask, then up to 11 served floors in order
// Unused floor slots hold f; a line starting with f ends the list
0 024 300 2 5 8 9 f f f f f f f
5 00a 480 7 a 3 1 f f f f f f f
a 011 040 6 4 0 f f f f f f f f
4 014 201 9 2 0 f f f f f f f f
7 2a2 044 9 6 5 2 1 f f f f f f
0 7ff 000 1 2 3 4 5 6 7 8 9 a f
2 004 004 f f f f f f f f f f f
6 021 000 5 0 f f f f f f f f f
3 400 001 a 0 f f f f f f f f f
5 250 002 6 9 4 1 f f f f f f f
f 000 000 f f f f f f f f f f f

// File: floor_request_ctrl.f
hdl/elevator_pkg.sv
hdl/request_latch.sv
hdl/target_scan.sv
hdl/dispatch_ctrl.sv
hdl/floor_request_ctrl.sv
bench/floor_request_ctrl_asserts.sv
bench/floor_request_ctrl_tb.sv

// File: hdl/dispatch_ctrl.sv
// Dispatch offer toward the motion FSM with a valid/ready handshake.
// After a transfer it waits until the car has moved and stopped again,
// remembers the sweep direction and registers the door grants.

`timescale 1ns/100ps

module dispatch_ctrl (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::scan_pick_t  pick,
    input  elevator_pkg::car_status_t status,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      dispatch_ready,
    output elevator_pkg::dispatch_t   dispatch,
    output logic                      dispatch_valid,
    output logic                      last_up,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    logic busy;
    logic seen_moving;
    logic idle;
    logic transfer;
    logic load_offer;

    // Free to make a new offer
    assign idle = !busy && !dispatch_valid && status.power_on
               && !status.emergency && !status.moving;

    assign transfer   = dispatch_valid && dispatch_ready;
    assign load_offer = idle && pick.found;

    ////////////////////////////////////////
    // Offer and travel tracking
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dispatch_valid <= 1'b0;
            busy           <= 1'b0;
            seen_moving    <= 1'b0;
            last_up        <= 1'b1;
        end else begin
            if (transfer) begin
                dispatch_valid <= 1'b0;
                busy           <= 1'b1;
                seen_moving    <= 1'b0;
                last_up        <= dispatch.up;
            end else if (load_offer) begin
                dispatch_valid <= 1'b1;
            end

            // Busy ends at the first stop after the car has moved
            if (busy) begin
                if (status.moving) begin
                    seen_moving <= 1'b1;
                end else if (seen_moving) begin
                    busy        <= 1'b0;
                    seen_moving <= 1'b0;
                end
            end
        end
    end

    // Offer payload, held steady while valid waits for ready
    always_ff @(posedge clock) begin
        if (load_offer) begin
            dispatch.floor <= pick.floor;
            dispatch.up    <= pick.up;
        end
    end

    ////////////////////////////////////////
    // Door grants
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_button && !status.moving && status.power_on;
            door_close_allowed <= door_close_button && !status.moving && status.power_on;
        end
    end

endmodule

// File: hdl/elevator_pkg.sv
// Shared floor constants and bundled types for the floor request controller.
// Every RTL and bench file refers to these through elevator_pkg:: scoped names.

package elevator_pkg;

    ////////////////////////////////////////
    // Building geometry
    ////////////////////////////////////////

    localparam int num_floors = 11;

    // Enough bits to index every floor
    localparam int floor_bits = $clog2(num_floors);

    // Floor index, 0 is the lowest floor
    typedef logic [floor_bits-1:0] floor_t;

    // One bit per floor, bit i for floor i
    typedef logic [num_floors-1:0] floor_mask_t;

    ////////////////////////////////////////
    // Button and light banks
    ////////////////////////////////////////

    // Same layout for raw buttons and latched lights
    typedef struct packed {
        floor_mask_t call;      // hall call buttons
        floor_mask_t panel;     // car panel buttons
    } button_bank_t;

    ////////////////////////////////////////
    // Car side status and dispatch
    ////////////////////////////////////////

    // Status reported by the car and the operator panel
    typedef struct packed {
        floor_t floor;
        logic   moving;
        logic   power_on;
        logic   emergency;
    } car_status_t;

    // Result of the sweep search
    typedef struct packed {
        logic   found;
        floor_t floor;
        logic   up;
    } scan_pick_t;

    // Target handed to the motion FSM
    typedef struct packed {
        floor_t floor;
        logic   up;
    } dispatch_t;

endpackage

// File: hdl/floor_request_ctrl.sv
// Top level of the floor request controller.
// Request lights feed the sweep search, whose pick feeds the dispatch stage.

`timescale 1ns/100ps

module floor_request_ctrl (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::button_bank_t buttons,
    input  elevator_pkg::car_status_t  status,
    input  logic                       door_open_button,
    input  logic                       door_close_button,
    input  logic                       dispatch_ready,
    output elevator_pkg::dispatch_t    dispatch,
    output logic                       dispatch_valid,
    output elevator_pkg::button_bank_t lights,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    elevator_pkg::scan_pick_t pick;
    logic                     last_up;

    request_latch u_request_latch (
        .clock   (clock),
        .reset_n (reset_n),
        .buttons (buttons),
        .status  (status),
        .lights  (lights)
    );

    target_scan u_target_scan (
        .lights    (lights),
        .car_floor (status.floor),
        .last_up   (last_up),
        .pick      (pick)
    );

    dispatch_ctrl u_dispatch_ctrl (
        .clock              (clock),
        .reset_n            (reset_n),
        .pick               (pick),
        .status             (status),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .dispatch_ready     (dispatch_ready),
        .dispatch           (dispatch),
        .dispatch_valid     (dispatch_valid),
        .last_up            (last_up),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// File: hdl/request_latch.sv
// Request light bank for hall calls and car panel buttons.
// Presses latch in parallel while the car is powered and not in emergency,
// and both lights of the current floor clear whenever the car is stopped.

`timescale 1ns/100ps

module request_latch (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::button_bank_t buttons,
    input  elevator_pkg::car_status_t  status,
    output elevator_pkg::button_bank_t lights
);

    elevator_pkg::floor_mask_t    here_mask;
    elevator_pkg::floor_mask_t    set_mask;
    elevator_pkg::floor_mask_t    clear_mask;
    elevator_pkg::button_bank_t   lights_next;

    // One bank update, shared by the call and panel lights
    function automatic elevator_pkg::floor_mask_t update_bank(
        input elevator_pkg::floor_mask_t held,
        input elevator_pkg::floor_mask_t press,
        input elevator_pkg::floor_mask_t set_en,
        input elevator_pkg::floor_mask_t clr_en
    );
        elevator_pkg::floor_mask_t result;
        result = (held | (press & set_en)) & ~clr_en;
        return result;
    endfunction

    ////////////////////////////////////////
    // Set and clear masks
    ////////////////////////////////////////

    // Bit of the floor the car stands at
    assign here_mask = elevator_pkg::floor_mask_t'(1) << status.floor;

    // Presses of the current floor never latch
    assign set_mask = (status.power_on && !status.emergency) ? ~here_mask : '0;

    // Arrival clear wins over any press of the same floor
    assign clear_mask = status.moving ? '0 : here_mask;

    always_comb begin
        lights_next.call  = update_bank(lights.call, buttons.call, set_mask, clear_mask);
        lights_next.panel = update_bank(lights.panel, buttons.panel, set_mask, clear_mask);
    end

    ////////////////////////////////////////
    // Light registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            lights <= lights_next;
        end
    end

endmodule

// File: hdl/target_scan.sv
// Sweep search over the pending requests.
// Keeps the last travel direction while requests remain that way, else
// reverses; within a direction the nearest request wins. Purely combinational.

`timescale 1ns/100ps

module target_scan (
    input  elevator_pkg::button_bank_t lights,
    input  elevator_pkg::floor_t       car_floor,
    input  logic                       last_up,
    output elevator_pkg::scan_pick_t   pick
);

    elevator_pkg::floor_mask_t pending;
    logic                      above_found;
    elevator_pkg::floor_t      above_floor;
    logic                      below_found;
    elevator_pkg::floor_t      below_floor;

    // Both banks count, the current floor never does
    assign pending = (lights.call | lights.panel)
                   & ~(elevator_pkg::floor_mask_t'(1) << car_floor);

    // Nearest above: walk down from the top, the last hit is the lowest
    always_comb begin
        above_found = 1'b0;
        above_floor = '0;
        for (int i = elevator_pkg::num_floors - 1; i >= 0; i--) begin
            if (pending[i] && (i > int'(car_floor))) begin
                above_found = 1'b1;
                above_floor = elevator_pkg::floor_t'(i);
            end
        end
    end

    // Nearest below: walk up from the bottom, the last hit is the highest
    always_comb begin
        below_found = 1'b0;
        below_floor = '0;
        for (int i = 0; i < elevator_pkg::num_floors; i++) begin
            if (pending[i] && (i < int'(car_floor))) begin
                below_found = 1'b1;
                below_floor = elevator_pkg::floor_t'(i);
            end
        end
    end

    ////////////////////////////////////////
    // Direction preference
    ////////////////////////////////////////

    always_comb begin
        pick = '0;
        if ((last_up && above_found) || (!last_up && above_found && !below_found)) begin
            pick.found = 1'b1;
            pick.floor = above_floor;
            pick.up    = 1'b1;
        end else if (below_found) begin
            pick.found = 1'b1;
            pick.floor = below_floor;
            pick.up    = 1'b0;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert --top-module floor_request_ctrl_tb \
    -f floor_request_ctrl.f > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vfloor_request_ctrl_tb > sim.log 2>&1
grep -q "^Test completed successfully$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
